//--- src/ym_reg_cfg.svh
`ifndef YM_REG_CFG_SVH
`define YM_REG_CFG_SVH

// slot timing. A sample period visits every operator of every channel once.
`define YM_SLOTS 24
`define YM_SLOT_W 5

// register field widths.
`define YM_FNUM_W 11
`define YM_BLOCK_W 3
`define YM_TL_W 7
`define YM_MULTI_W 4
`define YM_DT_W 3

// global key-on register, bank 0 only.
`define YM_ADDR_KEYON 8'h28

// operator register groups, taken from address bits [7:4].
`define YM_OP_MULDT 4'h3
`define YM_OP_TL 4'h4

// channel registers, taken from address bits [7:2].
`define YM_CH_FNUM_LO 6'h28 // register 0xA0.
`define YM_CH_FNUM_HI 6'h29 // register 0xA4.

`endif

//--- src/ym_reg_pkg.sv
package ym_reg_pkg;

	// held register address {bank, address byte}.
	// operator registers put the operator in bits [3:2]; channel registers
	// use all six upper bits as the register select.
	typedef union packed {
		struct packed {
			logic       bank;
			logic [3:0] group;
			logic [1:0] op;
			logic [1:0] ch;
		} op;
		struct packed {
			logic       bank;
			logic [5:0] regsel;
			logic [1:0] ch;
		} chn;
	} reg_addr_u;

endpackage

//--- src/ym_bus_latch.sv
module ym_bus_latch
	import ym_reg_pkg::*;
(
	input  logic       mclk_i,
	input  logic       arst_n_i,
	input  logic [7:0] data_i,
	input  logic       bank_i,
	input  logic       addr_wr_i,
	input  logic       data_wr_i,
	output reg_addr_u  addr_o,
	output logic [7:0] wdata_o,
	output logic       pending_o
);

	logic       fm_addr_wr;
	logic       fm_data_wr;
	logic       addr_valid_q;
	logic       pending_q;
	reg_addr_u  addr_q;
	logic [7:0] wdata_q;

	assign fm_addr_wr = addr_wr_i && (data_i[7:4] != 4'h0); // 0x00..0x0f is not an FM register.
	assign fm_data_wr = data_wr_i && addr_valid_q;

	always_ff @(posedge mclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			addr_valid_q <= 1'b0;
			pending_q    <= 1'b0;
		end else begin
			if (addr_wr_i) begin
				addr_valid_q <= fm_addr_wr;
				pending_q    <= 1'b0; // a new address ends the previous write.
			end else if (fm_data_wr) begin
				pending_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge mclk_i) begin
		if (fm_addr_wr) begin
			addr_q <= {bank_i, data_i};
		end
		if (fm_data_wr) begin
			wdata_q <= data_i;
		end
	end

	assign addr_o    = addr_q;
	assign wdata_o   = wdata_q;
	assign pending_o = pending_q;

	// the host interface has no arbitration between the two strobes
	a_strobe_excl: assert property (
		@(posedge mclk_i) disable iff (!arst_n_i)
		!(addr_wr_i && data_wr_i)
	) else $error("address and data strobes asserted in the same cycle");

endmodule

//--- src/ym_slot_counter.sv
`include "ym_reg_cfg.svh"

module ym_slot_counter
	import ym_reg_pkg::*;
(
	input  logic                  mclk_i,
	input  logic                  arst_n_i,
	input  reg_addr_u             addr_i,
	input  logic                  pending_i,
	output logic [`YM_SLOT_W-1:0] slot_o,
	output logic                  op_hit_o,
	output logic                  ch_hit_o
);

	logic                    run_q;
	logic [1:0]              cnt_lo_q;
	logic [`YM_SLOT_W-3:0]   cnt_hi_q;
	logic                    ch_match;
	logic                    op_match;

	always_ff @(posedge mclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			run_q    <= 1'b0;
			cnt_lo_q <= '0;
			cnt_hi_q <= '0;
		end else begin
			run_q <= 1'b1; // slot 0 is held for one cycle after reset.
			if (run_q) begin
				if (cnt_lo_q == 2'd2) begin
					cnt_lo_q <= '0;
					cnt_hi_q <= cnt_hi_q + 1'b1; // wraps after eight steps.
				end else begin
					cnt_lo_q <= cnt_lo_q + 1'b1;
				end
			end
		end
	end

	assign slot_o = {cnt_hi_q, cnt_lo_q};

	// slot bits: [1:0] channel, [2] part, [4:3] operator.
	assign ch_match = (slot_o[1:0] == addr_i.chn.ch) && (slot_o[2] == addr_i.chn.bank);
	assign op_match = ch_match && (slot_o[4:3] == addr_i.op.op);

	assign ch_hit_o = pending_i && ch_match;
	assign op_hit_o = pending_i && op_match;

	a_lo_range: assert property (
		@(posedge mclk_i) disable iff (!arst_n_i)
		cnt_lo_q != 2'd3
	) else $error("slot counter low bits reached 3");

endmodule

//--- src/ym_op_regs.sv
`include "ym_reg_cfg.svh"

module ym_op_regs
	import ym_reg_pkg::*;
(
	input  logic                   mclk_i,
	input  logic                   arst_n_i,
	input  reg_addr_u              addr_i,
	input  logic [7:0]             wdata_i,
	input  logic                   op_hit_i,
	output logic [`YM_MULTI_W-1:0] multi_o,
	output logic [`YM_DT_W-1:0]    dt_o,
	output logic [`YM_TL_W-1:0]    tl_o
);

	// one ring entry per slot, packed as {dt, multi, tl}.
	localparam int MULTI_LSB = `YM_TL_W;
	localparam int DT_LSB    = `YM_TL_W + `YM_MULTI_W;
	localparam int ENTRY_W   = `YM_TL_W + `YM_MULTI_W + `YM_DT_W;

	logic [ENTRY_W-1:0]     ring [`YM_SLOTS];
	logic [ENTRY_W-1:0]     head;
	logic [ENTRY_W-1:0]     head_next;
	logic                   wr_muldt;
	logic                   wr_tl;
	logic [`YM_MULTI_W-1:0] head_multi;
	logic [`YM_DT_W-1:0]    head_dt;
	logic [`YM_TL_W-1:0]    head_tl;

	assign head = ring[`YM_SLOTS-1]; // entry of the slot shown on slot_o.

	assign head_tl    = head[`YM_TL_W-1:0];
	assign head_multi = head[MULTI_LSB +: `YM_MULTI_W];
	assign head_dt    = head[DT_LSB +: `YM_DT_W];

	assign wr_muldt = op_hit_i && (addr_i.op.group == `YM_OP_MULDT);
	assign wr_tl    = op_hit_i && (addr_i.op.group == `YM_OP_TL);

	always_comb begin
		head_next = head;
		if (wr_muldt) begin
			head_next[MULTI_LSB +: `YM_MULTI_W] = wdata_i[`YM_MULTI_W-1:0];
			head_next[DT_LSB +: `YM_DT_W]       = wdata_i[`YM_MULTI_W +: `YM_DT_W];
		end
		if (wr_tl) begin
			head_next[`YM_TL_W-1:0] = wdata_i[`YM_TL_W-1:0];
		end
	end

	// the ring turns once per sample, so a write returns to the head
	// exactly when its slot comes round again.
	always_ff @(posedge mclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < `YM_SLOTS; i++) begin
				ring[i] <= '0;
			end
		end else begin
			ring[0] <= head_next;
			for (int i = 1; i < `YM_SLOTS; i++) begin
				ring[i] <= ring[i-1];
			end
		end
	end

	assign multi_o = head_multi;
	assign dt_o    = head_dt;
	assign tl_o    = head_tl;

endmodule

//--- src/ym_ch_regs.sv
`include "ym_reg_cfg.svh"

module ym_ch_regs
	import ym_reg_pkg::*;
(
	input  logic                   mclk_i,
	input  logic                   arst_n_i,
	input  reg_addr_u              addr_i,
	input  logic [7:0]             wdata_i,
	input  logic                   ch_hit_i,
	output logic [`YM_FNUM_W-1:0]  fnum_o,
	output logic [`YM_BLOCK_W-1:0] block_o,
	output logic [1:0]             note_o
);

	// the {part, channel} pattern repeats every six slots.
	localparam int CH_DEPTH = `YM_SLOTS / 4;
	localparam int HI_W     = `YM_BLOCK_W + `YM_FNUM_W - 8;
	localparam int FREQ_W   = `YM_BLOCK_W + `YM_FNUM_W;

	logic [HI_W-1:0]       hi_ring [CH_DEPTH];
	logic [FREQ_W-1:0]     freq_ring [`YM_SLOTS];
	logic [HI_W-1:0]       hi_head;
	logic [FREQ_W-1:0]     freq_head;
	logic                  wr_a0;
	logic                  wr_a4;
	logic [`YM_FNUM_W-1:0] fnum;

	assign wr_a0 = ch_hit_i && (addr_i.chn.regsel == `YM_CH_FNUM_LO);
	assign wr_a4 = ch_hit_i && (addr_i.chn.regsel == `YM_CH_FNUM_HI);

	assign hi_head   = hi_ring[CH_DEPTH-1];
	assign freq_head = freq_ring[`YM_SLOTS-1];

	always_ff @(posedge mclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < CH_DEPTH; i++) begin
				hi_ring[i] <= '0;
			end
		end else begin
			hi_ring[0] <= wr_a4 ? wdata_i[HI_W-1:0] : hi_head; // {block, fnum[10:8]}.
			for (int i = 1; i < CH_DEPTH; i++) begin
				hi_ring[i] <= hi_ring[i-1];
			end
		end
	end

	// every operator slot of the channel takes the committed value.
	always_ff @(posedge mclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < `YM_SLOTS; i++) begin
				freq_ring[i] <= '0;
			end
		end else begin
			freq_ring[0] <= wr_a0 ? {hi_head, wdata_i} : freq_head;
			for (int i = 1; i < `YM_SLOTS; i++) begin
				freq_ring[i] <= freq_ring[i-1];
			end
		end
	end

	assign fnum    = freq_head[`YM_FNUM_W-1:0];
	assign fnum_o  = fnum;
	assign block_o = freq_head[FREQ_W-1 -: `YM_BLOCK_W];

	assign note_o[1] = fnum[10];
	assign note_o[0] = fnum[10] ? (fnum[9:7] != 3'h0) : (fnum[9:7] == 3'h7);

endmodule

//--- src/ym_key_on.sv
`include "ym_reg_cfg.svh"

module ym_key_on (
	input  logic                  mclk_i,
	input  logic                  arst_n_i,
	input  logic [7:0]            wdata_i,
	input  logic                  pending_i,
	input  logic [8:0]            addr_i,
	input  logic [`YM_SLOT_W-1:0] slot_i,
	output logic                  kon_o
);

	localparam int         CH_DEPTH = `YM_SLOTS / 4;
	localparam logic [1:0] LOAD_OP  = 2'd3; // load on the last operator slot of the channel.

	logic                wr_kon;
	logic                ch_match;
	logic [2:0]          ch_q;
	logic [3:0]          mask_q;
	logic [3:0]          kon_load;
	logic [3:0]          kon_in;
	logic [CH_DEPTH-1:0] kon_sr [4];

	assign wr_kon = pending_i && (addr_i == {1'b0, `YM_ADDR_KEYON});

	always_ff @(posedge mclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ch_q   <= '0;
			mask_q <= '0;
		end else if (wr_kon) begin
			ch_q   <= wdata_i[2:0]; // {part, channel}.
			mask_q <= wdata_i[7:4];
		end
	end

	assign ch_match = (slot_i == {LOAD_OP, ch_q});

	// ring o is presented on operator o; rings take mask bits 0, 3, 1, 2.
	assign kon_load = {mask_q[2], mask_q[1], mask_q[3], mask_q[0]};

	always_comb begin
		for (int o = 0; o < 4; o++) begin
			kon_in[o] = ch_match ? kon_load[o] : kon_sr[(o + 1) % 4][CH_DEPTH-1];
		end
	end

	always_ff @(posedge mclk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int o = 0; o < 4; o++) begin
				kon_sr[o] <= '0;
			end
		end else begin
			for (int o = 0; o < 4; o++) begin
				kon_sr[o] <= {kon_sr[o][CH_DEPTH-2:0], kon_in[o]};
			end
		end
	end

	assign kon_o = kon_sr[0][CH_DEPTH-1];

endmodule

//--- src/ym_reg_ctrl.sv
`include "ym_reg_cfg.svh"

module ym_reg_ctrl
	import ym_reg_pkg::*;
(
	input  logic                   mclk_i,
	input  logic                   arst_n_i,
	input  logic [7:0]             data_i,
	input  logic                   bank_i,
	input  logic                   addr_wr_i,
	input  logic                   data_wr_i,
	output logic [`YM_SLOT_W-1:0]  slot_o,
	output logic [`YM_MULTI_W-1:0] multi_o,
	output logic [`YM_DT_W-1:0]    dt_o,
	output logic [`YM_TL_W-1:0]    tl_o,
	output logic [`YM_FNUM_W-1:0]  fnum_o,
	output logic [`YM_BLOCK_W-1:0] block_o,
	output logic [1:0]             note_o,
	output logic                   kon_o
);

	reg_addr_u  addr;
	logic [7:0] wdata;
	logic       pending;
	logic       op_hit;
	logic       ch_hit;

	ym_bus_latch u_bus_latch (
		.mclk_i    (mclk_i),
		.arst_n_i  (arst_n_i),
		.data_i    (data_i),
		.bank_i    (bank_i),
		.addr_wr_i (addr_wr_i),
		.data_wr_i (data_wr_i),
		.addr_o    (addr),
		.wdata_o   (wdata),
		.pending_o (pending)
	);

	ym_slot_counter u_slot_counter (
		.mclk_i    (mclk_i),
		.arst_n_i  (arst_n_i),
		.addr_i    (addr),
		.pending_i (pending),
		.slot_o    (slot_o),
		.op_hit_o  (op_hit),
		.ch_hit_o  (ch_hit)
	);

	ym_op_regs u_op_regs (
		.mclk_i   (mclk_i),
		.arst_n_i (arst_n_i),
		.addr_i   (addr),
		.wdata_i  (wdata),
		.op_hit_i (op_hit),
		.multi_o  (multi_o),
		.dt_o     (dt_o),
		.tl_o     (tl_o)
	);

	ym_ch_regs u_ch_regs (
		.mclk_i   (mclk_i),
		.arst_n_i (arst_n_i),
		.addr_i   (addr),
		.wdata_i  (wdata),
		.ch_hit_i (ch_hit),
		.fnum_o   (fnum_o),
		.block_o  (block_o),
		.note_o   (note_o)
	);

	ym_key_on u_key_on (
		.mclk_i    (mclk_i),
		.arst_n_i  (arst_n_i),
		.wdata_i   (wdata),
		.pending_i (pending),
		.addr_i    (addr),
		.slot_i    (slot_o),
		.kon_o     (kon_o)
	);

endmodule

//--- tests/tb_ym_reg_ctrl.sv
`include "ym_reg_cfg.svh"

module tb_ym_reg_ctrl;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int SETTLE      = 56; // data strobe to output, two slot rounds and a margin.
	localparam int TIMEOUT     = 200;
	localparam int N_SLOT      = 1 << `YM_SLOT_W;
	localparam int KON_SRC [4] = '{0, 3, 1, 2}; // mask bit shown on each operator slot.

	logic                   mclk;
	logic                   arst_n;
	logic [7:0]             data;
	logic                   bank;
	logic                   addr_wr;
	logic                   data_wr;
	logic [`YM_SLOT_W-1:0]  slot;
	logic [`YM_MULTI_W-1:0] multi;
	logic [`YM_DT_W-1:0]    dt;
	logic [`YM_TL_W-1:0]    tl;
	logic [`YM_FNUM_W-1:0]  fnum;
	logic [`YM_BLOCK_W-1:0] block;
	logic [1:0]             note;
	logic                   kon;

	// expected register contents, one entry per slot number.
	logic [`YM_MULTI_W-1:0] exp_multi [N_SLOT];
	logic [`YM_DT_W-1:0]    exp_dt [N_SLOT];
	logic [`YM_TL_W-1:0]    exp_tl [N_SLOT];
	logic [`YM_FNUM_W-1:0]  exp_fnum [N_SLOT];
	logic [`YM_BLOCK_W-1:0] exp_block [N_SLOT];
	logic                   exp_kon [N_SLOT];
	logic [5:0]             a4_latch [8]; // indexed by {part, channel}.
	int                     stamp [N_SLOT]; // cycle of the last write that touched the slot.
	int                     last_stamp;
	int                     cycle_cnt;
	int                     write_count;
	int                     error_count;
	logic                   settled;

	ym_reg_ctrl ym_reg_ctrl_i (
		.mclk_i    (mclk),
		.arst_n_i  (arst_n),
		.data_i    (data),
		.bank_i    (bank),
		.addr_wr_i (addr_wr),
		.data_wr_i (data_wr),
		.slot_o    (slot),
		.multi_o   (multi),
		.dt_o      (dt),
		.tl_o      (tl),
		.fnum_o    (fnum),
		.block_o   (block),
		.note_o    (note),
		.kon_o     (kon)
	);

	initial begin
		mclk = 1'b0;
		forever #50 mclk = ~mclk;
	end

	always @(posedge mclk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	assign settled = (cycle_cnt - stamp[slot]) > SETTLE;

	function automatic logic [1:0] note_of(input logic [`YM_FNUM_W-1:0] f);
		if (f[10]) begin
			return {1'b1, f[9:7] != 3'd0};
		end
		return {1'b0, f[9:7] == 3'd7};
	endfunction

	// channel steps 0, 1, 2, then the part and operator bits move on by one.
	function automatic logic [`YM_SLOT_W-1:0] next_slot(input logic [`YM_SLOT_W-1:0] s);
		if (s[1:0] == 2'd2) begin
			return {s[4:2] + 3'd1, 2'd0};
		end
		return s + 1'b1;
	endfunction

	task automatic report_mismatch(input string what, input logic [`YM_SLOT_W-1:0] s);
		error_count++;
		$display("MISMATCH at %0d ns: %s differs from the model on slot %0d", $time, what, s);
	endtask

	a_slot: assert property (@(posedge mclk) disable iff (!arst_n)
		$past(arst_n, 2) |-> (slot == next_slot($past(slot))))
		else report_mismatch("slot number", $sampled(slot));

	a_op_fields: assert property (@(posedge mclk) disable iff (!arst_n)
		settled |-> (multi == exp_multi[slot] && dt == exp_dt[slot] && tl == exp_tl[slot]))
		else report_mismatch("multiple, detune or total level", $sampled(slot));

	a_freq: assert property (@(posedge mclk) disable iff (!arst_n)
		settled |-> (fnum == exp_fnum[slot] && block == exp_block[slot]))
		else report_mismatch("fnum or block", $sampled(slot));

	a_note: assert property (@(posedge mclk) disable iff (!arst_n)
		settled |-> (note == note_of(exp_fnum[slot])))
		else report_mismatch("note", $sampled(slot));

	a_kon: assert property (@(posedge mclk) disable iff (!arst_n)
		settled |-> (kon == exp_kon[slot]))
		else report_mismatch("key on", $sampled(slot));

	task automatic apply_model(input logic b, input logic [7:0] a, input logic [7:0] d);
		logic [`YM_SLOT_W-1:0] s;
		logic [2:0]            pc;
		pc = {b, a[1:0]};
		if (a[7:4] == `YM_OP_MULDT && a[1:0] != 2'd3) begin
			s = {a[3:2], b, a[1:0]};
			exp_multi[s] = d[3:0];
			exp_dt[s]    = d[6:4];
			stamp[s]     = cycle_cnt;
		end else if (a[7:4] == `YM_OP_TL && a[1:0] != 2'd3) begin
			s = {a[3:2], b, a[1:0]};
			exp_tl[s] = d[6:0];
			stamp[s]  = cycle_cnt;
		end else if (a[7:2] == `YM_CH_FNUM_HI && a[1:0] != 2'd3) begin
			a4_latch[pc] = d[5:0];
		end else if (a[7:2] == `YM_CH_FNUM_LO && a[1:0] != 2'd3) begin
			for (int o = 0; o < 4; o++) begin
				s = {2'(o), pc};
				exp_fnum[s]  = {a4_latch[pc][2:0], d};
				exp_block[s] = a4_latch[pc][5:3];
				stamp[s]     = cycle_cnt;
			end
		end else if (!b && a == `YM_ADDR_KEYON && d[1:0] != 2'd3) begin
			for (int o = 0; o < 4; o++) begin
				s = {2'(o), d[2:0]};
				exp_kon[s] = d[4 + KON_SRC[o]];
				stamp[s]   = cycle_cnt;
			end
		end
	endtask

	task automatic strobe(input logic is_addr, input logic b, input logic [7:0] d);
		bank    = b;
		data    = d;
		addr_wr = is_addr;
		data_wr = !is_addr;
		@(posedge mclk);
		#10;
		addr_wr = 1'b0;
		data_wr = 1'b0;
	endtask

	// returns once every slot has been shown settled for a full round.
	task automatic wait_settled();
		int n;
		n = 0;
		while (cycle_cnt - last_stamp <= SETTLE + `YM_SLOTS) begin
			@(posedge mclk);
			#10;
			n++;
			if (n > TIMEOUT) begin
				$display("timeout while waiting for the register outputs to settle");
				$display("TESTS FAILED");
				$finish;
			end
		end
	endtask

	task automatic reg_write(input logic b, input logic [7:0] a, input logic [7:0] d);
		strobe(1'b1, b, a);
		@(posedge mclk);
		#10;
		strobe(1'b0, b, d);
		last_stamp = cycle_cnt;
		apply_model(b, a, d);
		write_count++;
		wait_settled();
	endtask

	initial begin
		int unsigned r;
		void'($urandom(32'h09bdc20c));
		arst_n      = 1'b0;
		data        = 8'h00;
		bank        = 1'b0;
		addr_wr     = 1'b0;
		data_wr     = 1'b0;
		cycle_cnt   = 0;
		last_stamp  = 0;
		write_count = 0;
		error_count = 0;
		for (int i = 0; i < N_SLOT; i++) begin
			exp_multi[i] = '0;
			exp_dt[i]    = '0;
			exp_tl[i]    = '0;
			exp_fnum[i]  = '0;
			exp_block[i] = '0;
			exp_kon[i]   = 1'b0;
			stamp[i]     = -1000;
		end
		for (int i = 0; i < 8; i++) begin
			a4_latch[i] = '0;
		end
		repeat (3) @(posedge mclk);
		#10;
		arst_n = 1'b1;
		wait_settled(); // all slots show their reset values.
		for (int i = 0; i < 20; i++) begin
			r = $urandom();
			reg_write(r[5], {(r[0] ? `YM_OP_TL : `YM_OP_MULDT), r[4:1]}, r[15:8]);
		end
		for (int i = 0; i < 12; i++) begin
			r = $urandom();
			if (i == 0) begin
				r[2:1]   = 2'b00;
				r[10:8]  = 3'b011; // fnum 0x380 hits the all-ones case of the low note bit.
				r[23]    = 1'b1;
				r[22:16] = 7'h00;
			end else if (i == 1) begin
				r[2:1]  = 2'b01;
				r[10:8] = 3'b100; // fnum[10] set with fnum[9:7] clear.
				r[23]   = 1'b0;
			end
			reg_write(r[0], {`YM_CH_FNUM_HI, r[2:1]}, r[15:8]);
			reg_write(r[0], {`YM_CH_FNUM_LO, r[2:1]}, r[23:16]);
		end
		for (int i = 0; i < 10; i++) begin
			r = $urandom();
			reg_write(1'b0, `YM_ADDR_KEYON, {r[7:4], 1'b0, r[2:0]});
		end
		for (int i = 0; i < 4; i++) begin
			r = $urandom();
			reg_write(r[0], {`YM_OP_TL, r[4:1]}, r[15:8]);
			reg_write(r[0], {4'h0, r[4:1]}, r[23:16]); // not an FM address, so data is dropped.
		end
		$display("%0d register writes, %0d mismatches", write_count, error_count);
		if (error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- ym_reg_ctrl.f
+incdir+src
src/ym_reg_pkg.sv
src/ym_bus_latch.sv
src/ym_slot_counter.sv
src/ym_op_regs.sv
src/ym_ch_regs.sv
src/ym_key_on.sv
src/ym_reg_ctrl.sv
tests/tb_ym_reg_ctrl.sv
